//--- build.f
+incdir+design
design/core_pkg.sv
design/instr_decode.sv
design/exec_units.sv
design/ex_wb.sv
design/wb_stage.sv
design/backend_top.sv
sim/ex_wb_checker.sv
sim/backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the back end with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module backend_tb -f build.f \
    && ./obj_dir/Vbackend_tb 2>&1 | tee sim.log \
    || { echo "build or simulation did not finish cleanly"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
exit 0

//--- sim/backend_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the back end: random program with hazard-free sources,
// random stall, in-order reference model and completion compare
// run through build.f; top module is backend_tb
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module backend_tb import core_pkg::*; ();

    localparam int NUM_INSTR   = 400;
    localparam int WATCHDOG_NS = NUM_INSTR * 4 * 20 + 2000;

    // expected completion: lane position plus the lane contents
    typedef struct packed {
        logic [1:0] lane;
        cmpl_t      c;
    } exp_t;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    issue_t                  issue;
    cmpl_t [`NUM_LANES-1:0]  done;

    logic [31:0]             seed = 32'ha97f88af;
    logic [`DATA_W-1:0]      model_prf [`NUM_PREGS];
    logic [`DATA_W-1:0]      model_mem [`DMEM_DEPTH];
    logic [`PREG_W-1:0]      hist [2];
    logic                    pair_pending;
    logic [`PREG_W-1:0]      pair_a;
    logic [`IMM_W-1:0]       pair_imm;
    exp_t                    exp_q [$];
    int                      n_issued;

    backend_top uut (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .issue (issue),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("timeout: the completions did not drain in time");
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // step past the destinations of the last two issued instructions
    function automatic logic [`PREG_W-1:0] pick_src(input logic [`PREG_W-1:0] s);
        logic [`PREG_W-1:0] v;
        v = s;
        while (v == hist[0] || v == hist[1])
            v = v + 6'd1;
        return v;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
        assert (act_v === exp_v) else begin
            fail_stop($sformatf("ERROR: time %0t %s expected %h actual %h",
                                $time, name, exp_v, act_v));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, one instruction in issue order
    ////////////////////////////////////////////////////////////////////////////
    function automatic exp_t ref_exec(input instr_u ins, input logic [`TAG_W-1:0] tag,
                                      input logic [`PREG_W-1:0] dst,
                                      input logic [`DATA_W-1:0] a,
                                      input logic [`DATA_W-1:0] b);
        exp_t               e;
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] ea;
        imm          = {{(`DATA_W-`IMM_W){ins.i.imm[`IMM_W-1]}}, ins.i.imm};
        ea           = a + imm;
        e.lane       = 2'(LANE_ALU1);
        e.c.vld      = 1'b1;
        e.c.idx      = tag;
        e.c.phy_addr = dst;
        e.c.reg_wrt  = 1'b1;
        e.c.data     = '0;
        case (ins.r.op)
            ALU_R: begin
                case (ins.r.fn)
                    ADD:     e.c.data = a + b;
                    SUB:     e.c.data = a - b;
                    AND:     e.c.data = a & b;
                    OR:      e.c.data = a | b;
                    XOR:     e.c.data = a ^ b;
                    SHL:     e.c.data = a << b[3:0];
                    SHR:     e.c.data = a >> b[3:0];
                    SLT:     e.c.data = {15'd0, $signed(a) < $signed(b)};
                    default: e.c.data = '0;
                endcase
            end
            ALU_I: begin
                e.lane   = 2'(LANE_ALU2);
                e.c.data = ea;
            end
            MUL: begin
                e.lane   = 2'(LANE_MULT);
                e.c.data = a * b;
            end
            LD: begin
                e.lane   = 2'(LANE_ADDR);
                e.c.data = model_mem[ea[5:0]];
            end
            ST: begin
                // the address comes back on the lane
                e.lane      = 2'(LANE_ADDR);
                e.c.reg_wrt = 1'b0;
                e.c.data    = ea;
            end
            default: e.c.reg_wrt = 1'b0;
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // random instruction, queued expectation and model update
    ////////////////////////////////////////////////////////////////////////////
    task automatic gen_instr(input logic [`TAG_W-1:0] tag, output issue_t p);
        logic [31:0]        r;
        logic [3:0]         op_raw;
        logic [3:0]         fn_raw;
        logic [`IMM_W-1:0]  imm;
        exp_t               e;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        seed    = lcg_next(seed);
        r       = seed;
        p       = '0;
        p.vld   = 1'b1;
        p.tag   = tag;
        p.dst   = r[5:0];
        p.src_a = pick_src(r[11:6]);
        p.src_b = pick_src(r[17:12]);
        seed    = lcg_next(seed);
        r       = seed;
        // codes 8 and 9 are undefined functions
        fn_raw  = 4'(r[7:0] % 8'd10);
        imm     = r[27:16];
        if (pair_pending) begin
            // load back the word just stored
            op_raw  = LD;
            p.src_a = pick_src(pair_a);
            imm     = pair_imm;
        end else begin
            case (r[31:28])
                4'd5, 4'd6, 4'd7: op_raw = ALU_I;
                4'd8, 4'd9:       op_raw = MUL;
                4'd10, 4'd11:     op_raw = LD;
                4'd12, 4'd13:     op_raw = ST;
                4'd14:            op_raw = 4'd5 + {1'b0, r[10:8]};
                default:          op_raw = ALU_R;
            endcase
        end
        pair_pending = 1'b0;
        if (op_raw == ALU_R || op_raw == MUL)
            p.instr = {op_raw, fn_raw, r[15:8]};
        else
            p.instr = {op_raw, imm};
        if (op_raw == ST) begin
            // no new hazard from a store
            p.dst        = hist[0];
            pair_pending = r[12];
            pair_a       = p.src_a;
            pair_imm     = imm;
        end
        a = model_prf[p.src_a];
        b = model_prf[p.src_b];
        e = ref_exec(p.instr, p.tag, p.dst, a, b);
        exp_q.push_back(e);
        if (e.c.reg_wrt)
            model_prf[p.dst] = e.c.data;
        if (op_raw == ST)
            model_mem[e.c.data[5:0]] = b;
        hist[1] = hist[0];
        hist[0] = p.dst;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin : drive_proc
        issue_t pkt;
        rst   <= 1'b1;
        stall <= 1'b0;
        issue <= '0;
        for (int i = 0; i < `NUM_PREGS; i++)
            model_prf[i] = '0;
        for (int i = 0; i < `DMEM_DEPTH; i++)
            model_mem[i] = '0;
        hist[0]      = '0;
        hist[1]      = '0;
        pair_pending = 1'b0;
        n_issued     = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (n_issued < NUM_INSTR) begin
            @(posedge clk);
            seed = lcg_next(seed);
            if (seed[31:30] == 2'b00) begin
                stall <= 1'b1;
                issue <= '0;
            end else begin
                gen_instr(6'(n_issued), pkt);
                stall <= 1'b0;
                issue <= pkt;
                n_issued++;
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        issue <= '0;
        while (exp_q.size() != 0)
            @(negedge clk);
        // a few quiet cycles catch a stray completion
        repeat (3) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare, sampled mid-cycle; a repeated tag is a held item
    ////////////////////////////////////////////////////////////////////////////
    initial begin : compare_proc
        int                nv;
        int                hit;
        logic              have_prev;
        logic [`TAG_W-1:0] prev_tag;
        exp_t              cur;
        have_prev = 1'b0;
        prev_tag  = '0;
        cur       = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                nv  = 0;
                hit = 0;
                for (int i = 0; i < `NUM_LANES; i++) begin
                    if (done[i].vld) begin
                        nv++;
                        hit = i;
                    end
                end
                if (nv == 0) begin
                    have_prev = 1'b0;
                end else begin
                    assert (nv == 1) else begin
                        fail_stop("more than one completion lane valid in one cycle");
                    end
                    if (!have_prev || done[hit].idx != prev_tag) begin
                        assert (exp_q.size() != 0) else begin
                            fail_stop("completion seen with no instruction outstanding");
                        end
                        cur = exp_q.pop_front();
                    end
                    check_val("done lane", 16'(cur.lane), 16'(hit));
                    check_val("done.idx", 16'(cur.c.idx), 16'(done[hit].idx));
                    check_val("done.phy_addr", 16'(cur.c.phy_addr),
                              16'(done[hit].phy_addr));
                    check_val("done.reg_wrt", 16'(cur.c.reg_wrt),
                              16'(done[hit].reg_wrt));
                    check_val("done.data", cur.c.data, done[hit].data);
                    prev_tag  = done[hit].idx;
                    have_prev = 1'b1;
                end
            end
        end
    end

endmodule

//--- sim/ex_wb_checker.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the back end: issue under stall, one completion
// lane per cycle, EX/WB hold under stall and a quiet first cycle
// bound into backend_top, seeing the EX/WB register through ex_q
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module ex_wb_checker import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  issue_t                  issue,
    input  cmpl_t [`NUM_LANES-1:0]  done,
    input  ex_wb_t                  q
);

    logic [`NUM_LANES-1:0] done_vld;

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++)
            done_vld[i] = done[i].vld;
    end

    // issuer keeps quiet while stalled
    a_no_issue_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !issue.vld)
        else $error("issue packet presented while stall is high");

    a_one_lane: assert property (@(posedge clk) disable iff (rst)
        $onehot0(done_vld))
        else $error("more than one completion lane valid");

    // EX/WB frozen for the whole stalled cycle
    a_hold_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(q))
        else $error("EX/WB register changed under stall");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (done_vld == '0))
        else $error("completion reported in the cycle after reset");

endmodule

bind backend_top ex_wb_checker u_chk (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .issue (issue),
    .done  (done),
    .q     (ex_q)
);

//--- design/backend_top.sv
////////////////////////////////////////////////////////////////////////////
// back end top: decode, execute, EX/WB register and write-back in a row
// one issue packet per cycle in, four completion lanes out
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module backend_top import core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  issue_t                   issue,
    output cmpl_t [`NUM_LANES-1:0]   done
);

    logic [`PREG_W-1:0] rd_addr_a;
    logic [`PREG_W-1:0] rd_addr_b;
    logic [`DATA_W-1:0] rd_data_a;
    logic [`DATA_W-1:0] rd_data_b;
    dec_t               dec;
    ex_wb_t             ex_d;
    ex_wb_t             ex_q;

    instr_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .issue     (issue),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .dec       (dec)
    );

    exec_units u_exec (
        .dec (dec),
        .ex  (ex_d)
    );

    // frozen together with decode under stall
    ex_wb u_ex_wb (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .d     (ex_d),
        .q     (ex_q)
    );

    wb_stage u_wb (
        .clk       (clk),
        .rst       (rst),
        .wb        (ex_q),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .done      (done)
    );

endmodule

//--- design/wb_stage.sv
////////////////////////////////////////////////////////////////////////////
// write-back: physical register file, data memory, load read and the
// four completion lanes; register reads feed decode combinationally
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module wb_stage import core_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  ex_wb_t                         wb,
    input  logic [`PREG_W-1:0]             rd_addr_a,
    input  logic [`PREG_W-1:0]             rd_addr_b,
    output logic [`DATA_W-1:0]             rd_data_a,
    output logic [`DATA_W-1:0]             rd_data_b,
    output cmpl_t [`NUM_LANES-1:0]         done
);

    localparam int DM_AW = $clog2(`DMEM_DEPTH);

    logic [`DATA_W-1:0] prf  [`NUM_PREGS];
    logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
    logic [DM_AW-1:0]   dm_addr;
    logic [`DATA_W-1:0] ld_data;
    lane_t              lane [`NUM_LANES];

    assign lane[LANE_ALU1] = wb.alu1;
    assign lane[LANE_ALU2] = wb.alu2;
    assign lane[LANE_MULT] = wb.mult;
    assign lane[LANE_ADDR] = wb.addr;

    // register file reads for decode
    assign rd_data_a = prf[rd_addr_a];
    assign rd_data_b = prf[rd_addr_b];

    // loads and stores both use the address lane
    assign dm_addr = wb.addr.out[DM_AW-1:0];
    assign ld_data = dmem[dm_addr];

    ////////////////////////////////////////////////////////////////////////////
    // completion lanes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            done[i].vld      = lane[i].done_vld;
            done[i].idx      = lane[i].done_idx;
            done[i].reg_wrt  = lane[i].reg_wrt;
            done[i].phy_addr = lane[i].phy_addr;
            done[i].data     = lane[i].out;
        end
        // ld returns the memory word, not the address
        if (lane[LANE_ADDR].mem_rd)
            done[LANE_ADDR].data = ld_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file and data memory writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PREGS; i++)
                prf[i] <= '0;
        end else begin
            for (int i = 0; i < `NUM_LANES; i++)
                if (done[i].vld && done[i].reg_wrt)
                    prf[done[i].phy_addr] <= done[i].data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (wb.addr.mem_wrt) begin
            dmem[dm_addr] <= wb.data_str;
        end
    end

endmodule

//--- design/ex_wb.sv
////////////////////////////////////////////////////////////////////////////
// EX/WB pipeline register: four result lanes, store data and the
// multiplier valid, loaded as one word and frozen while stall is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module ex_wb import core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  ex_wb_t  d,
    output ex_wb_t  q
);

    logic enable;

    // load on every cycle without stall
    assign enable = ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            // all valid, write and read flags drop together
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

//--- design/exec_units.sv
////////////////////////////////////////////////////////////////////////////
// execute stage: alu1, alu2, multiplier and address adder side by side
// purely combinational, one result lane per unit plus the store data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module exec_units import core_pkg::*; (
    input  dec_t    dec,
    output ex_wb_t  ex
);

    logic [`DATA_W-1:0] alu1_res;
    logic [`DATA_W-1:0] alu2_res;
    logic [`DATA_W-1:0] mult_res;
    logic [`DATA_W-1:0] addr_res;

    // one lane, valid only when its unit is selected
    function automatic lane_t fill_lane(input dec_t d, input unit_e u,
                                        input logic [`DATA_W-1:0] res);
        lane_t l;
        logic  sel;
        sel        = d.vld && (d.unit == u);
        l.done_vld = sel;
        l.done_idx = d.tag;
        l.phy_addr = d.dst;
        l.reg_wrt  = sel & d.reg_wrt;
        l.mem_rd   = sel & d.mem_rd;
        l.mem_wrt  = sel & d.mem_wrt;
        l.out      = res;
        return l;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // alu1, register operands
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (dec.fn)
            ADD:     alu1_res = dec.a + dec.b;
            SUB:     alu1_res = dec.a - dec.b;
            AND:     alu1_res = dec.a & dec.b;
            OR:      alu1_res = dec.a | dec.b;
            XOR:     alu1_res = dec.a ^ dec.b;
            // shift amount from low 4 bits of b
            SHL:     alu1_res = dec.a << dec.b[3:0];
            SHR:     alu1_res = dec.a >> dec.b[3:0];
            SLT:     alu1_res = `DATA_W'($signed(dec.a) < $signed(dec.b));
            default: alu1_res = '0;
        endcase
    end

    // alu2, immediate add
    assign alu2_res = dec.a + dec.imm;

    // multiplier keeps the low word
    assign mult_res = dec.a * dec.b;

    // load/store effective address
    assign addr_res = dec.a + dec.imm;

    ////////////////////////////////////////////////////////////////////////////
    // result lanes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        ex.alu1          = fill_lane(dec, ALU1, alu1_res);
        ex.alu2          = fill_lane(dec, ALU2, alu2_res);
        ex.mult          = fill_lane(dec, MULT, mult_res);
        ex.addr          = fill_lane(dec, ADDR, addr_res);
        // store word rides along with the address
        ex.data_str      = dec.b;
        ex.mult_valid_wb = ex.mult.done_vld;
    end

endmodule

//--- design/instr_decode.sv
////////////////////////////////////////////////////////////////////////////
// decode stage: reads both source registers, decodes the instruction
// word and registers one decoded item per cycle; holds under stall
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_decode import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  issue_t               issue,
    input  logic [`DATA_W-1:0]   rd_data_a,
    input  logic [`DATA_W-1:0]   rd_data_b,
    output logic [`PREG_W-1:0]   rd_addr_a,
    output logic [`PREG_W-1:0]   rd_addr_b,
    output dec_t                 dec
);

    dec_t                  dec_nxt;
    opcode_e               op;
    logic [`DATA_W-1:0]    imm_ext;

    // register file read ports
    assign rd_addr_a = issue.src_a;
    assign rd_addr_b = issue.src_b;

    // opcode sits in the same bits in both views
    assign op = issue.instr.r.op;

    // I view immediate, sign extended
    assign imm_ext = {{(`DATA_W-`IMM_W){issue.instr.i.imm[`IMM_W-1]}},
                      issue.instr.i.imm};

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dec_nxt         = '0;
        dec_nxt.vld     = issue.vld;
        dec_nxt.tag     = issue.tag;
        dec_nxt.dst     = issue.dst;
        dec_nxt.a       = rd_data_a;
        dec_nxt.b       = rd_data_b;
        dec_nxt.unit    = ALU1;
        dec_nxt.fn      = ADD;

        case (op)
            ALU_R: begin
                dec_nxt.unit    = ALU1;
                dec_nxt.fn      = issue.instr.r.fn;
                dec_nxt.reg_wrt = 1'b1;
            end
            ALU_I: begin
                dec_nxt.unit    = ALU2;
                dec_nxt.imm     = imm_ext;
                dec_nxt.reg_wrt = 1'b1;
            end
            MUL: begin
                dec_nxt.unit    = MULT;
                dec_nxt.reg_wrt = 1'b1;
            end
            LD: begin
                dec_nxt.unit    = ADDR;
                dec_nxt.imm     = imm_ext;
                dec_nxt.mem_rd  = 1'b1;
                dec_nxt.reg_wrt = 1'b1;
            end
            ST: begin
                dec_nxt.unit    = ADDR;
                dec_nxt.imm     = imm_ext;
                dec_nxt.mem_wrt = 1'b1;
            end
            default: begin
                // illegal opcode: completes on alu1 as 0 + 0, no write
                dec_nxt.a = '0;
                dec_nxt.b = '0;
            end
        endcase

        // a bubble has no side effects
        if (!issue.vld) begin
            dec_nxt.reg_wrt = 1'b0;
            dec_nxt.mem_rd  = 1'b0;
            dec_nxt.mem_wrt = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            dec.vld     <= 1'b0;
            dec.reg_wrt <= 1'b0;
            dec.mem_rd  <= 1'b0;
            dec.mem_wrt <= 1'b0;
        end else if (!stall) begin
            dec <= dec_nxt;
        end
    end

endmodule

//--- design/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types for the back end: opcodes, the two-format instruction word, and
// the structs passed between decode, execute, EX/WB and write-back
////////////////////////////////////////////////////////////////////////////
`include "core_defines.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_R = 4'd0,
        ALU_I = 4'd1,
        MUL   = 4'd2,
        LD    = 4'd3,
        ST    = 4'd4
    } opcode_e;

    // codes 8..15 are undefined and give zero
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SHL = 4'd5,
        SHR = 4'd6,
        SLT = 4'd7
    } alu_fn_e;

    typedef enum logic [1:0] {
        ALU1 = 2'd0,
        ALU2 = 2'd1,
        MULT = 2'd2,
        ADDR = 2'd3
    } unit_e;

    // lane positions on the done port
    localparam int LANE_ALU1 = 0;
    localparam int LANE_ALU2 = 1;
    localparam int LANE_MULT = 2;
    localparam int LANE_ADDR = 3;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word, register and immediate views
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        opcode_e    op;
        alu_fn_e    fn;
        logic [7:0] rsvd;
    } r_fmt_t;

    typedef struct packed {
        opcode_e              op;
        logic [`IMM_W-1:0]    imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic                 vld;
        instr_u               instr;
        logic [`TAG_W-1:0]    tag;
        logic [`PREG_W-1:0]   dst;
        logic [`PREG_W-1:0]   src_a;
        logic [`PREG_W-1:0]   src_b;
    } issue_t;

    typedef struct packed {
        logic                 vld;
        unit_e                unit;
        alu_fn_e              fn;
        logic [`DATA_W-1:0]   a;
        logic [`DATA_W-1:0]   b;
        logic [`DATA_W-1:0]   imm;
        logic [`TAG_W-1:0]    tag;
        logic [`PREG_W-1:0]   dst;
        logic                 reg_wrt;
        logic                 mem_rd;
        logic                 mem_wrt;
    } dec_t;

    ////////////////////////////////////////////////////////////////////////////
    // execute results and completions
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                 done_vld;
        logic [`TAG_W-1:0]    done_idx;
        logic [`PREG_W-1:0]   phy_addr;
        logic                 reg_wrt;
        logic                 mem_rd;
        logic                 mem_wrt;
        logic [`DATA_W-1:0]   out;
    } lane_t;

    typedef struct packed {
        lane_t                alu1;
        lane_t                alu2;
        lane_t                mult;
        lane_t                addr;
        logic [`DATA_W-1:0]   data_str;
        logic                 mult_valid_wb;
    } ex_wb_t;

    typedef struct packed {
        logic                 vld;
        logic [`TAG_W-1:0]    idx;
        logic                 reg_wrt;
        logic [`PREG_W-1:0]   phy_addr;
        logic [`DATA_W-1:0]   data;
    } cmpl_t;

endpackage

//--- design/core_defines.svh
////////////////////////////////////////////////////////////////////////////
// widths and depths shared by the back end RTL and its testbench
// include wherever a macro below is used; the guard makes repeats harmless
////////////////////////////////////////////////////////////////////////////
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath
`define DATA_W      16
`define IMM_W       12

// tags and physical registers
`define TAG_W       6
`define PREG_W      6
`define NUM_PREGS   64

// data memory, addressed by the low address bits
`define DMEM_DEPTH  64

// result lanes out of execute
`define NUM_LANES   4

`endif
